//--- logic/matrix_game_config.svh
//########################################
// Matrix game build constants
// Debounce, scroll and serial timing, start images
//########################################
`ifndef MATRIX_GAME_CONFIG_SVH
`define MATRIX_GAME_CONFIG_SVH

// Timing
`define MG_DEBOUNCE_CYCLES 16
`define MG_SCROLL_TICKS 65536
`define MG_SCLK_DIV 4
`define MG_INTENSITY 4'hA

// Start position of the player point
`define MG_POINT_INIT_ROW 0
`define MG_POINT_INIT_COL 4

// Obstacle rows at game start
`define MG_BACKG_INIT_0 8'b00000000
`define MG_BACKG_INIT_1 8'b00000000
`define MG_BACKG_INIT_2 8'b11100000
`define MG_BACKG_INIT_3 8'b00000000
`define MG_BACKG_INIT_4 8'b11100000
`define MG_BACKG_INIT_5 8'b00000000
`define MG_BACKG_INIT_6 8'b00000000
`define MG_BACKG_INIT_7 8'b11100000

`endif

//--- logic/matrix_game_pkg.sv
//########################################
// Matrix game shared types
//########################################
`default_nettype none

package matrix_game_pkg;

	// One matrix row, bit i drives column i
	typedef logic [7:0] row_t;

	// Full matrix image, index 0 is the bottom row
	typedef row_t [7:0] row_array_t;

	// Row or column index
	typedef logic [2:0] idx_t;

	// Counters
	typedef logic [16:0] scroll_cnt_t;
	typedef logic [4:0] deb_cnt_t;

	// MAX7219 word, address in [15:8], data in [7:0]
	typedef logic [15:0] frame_t;

	// State machines
	typedef enum logic {IDLE, PLAY} game_state_t;
	typedef enum logic [1:0] {LOAD, SHIFT, GAP} drv_state_t;

endpackage

`default_nettype wire

//--- logic/button_if.sv
//########################################
// Debounced button strobes
//########################################
`timescale 1ns/1ps
`default_nettype none

interface button_if;

	// One-cycle press strobes
	logic start;
	logic up;
	logic down;
	logic left;
	logic right;

	modport src (output start, up, down, left, right);
	modport dst (input start, up, down, left, right);

endinterface

`default_nettype wire

//--- logic/button_debounce.sv
//########################################
// Button debouncer bank
// Five active-low keys to one strobe per press
//########################################
`timescale 1ns/1ps
`default_nettype none
`include "matrix_game_config.svh"

module button_debounce import matrix_game_pkg::*; (
	input logic clock_50,
	input logic arst_n,
	input logic start_button_n,
	input logic up_button_n,
	input logic down_button_n,
	input logic left_button_n,
	input logic right_button_n,
	button_if.src btn
);

	localparam int NCH = 5;

	logic [NCH-1:0] raw_n;
	logic [NCH-1:0] sync_1;
	logic [NCH-1:0] sync_2;
	logic [NCH-1:0] fired;
	logic [NCH-1:0] strobe;
	deb_cnt_t cnt [NCH];

	// Channel order matches the interface fields
	assign raw_n = {right_button_n, left_button_n, down_button_n, up_button_n, start_button_n};

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
			fired  <= '0;
			strobe <= '0;
			for (int i = 0; i < NCH; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			// Two-flop synchronizer, high means pressed
			sync_1 <= ~raw_n;
			sync_2 <= sync_1;
			for (int i = 0; i < NCH; i++) begin
				strobe[i] <= 1'b0;
				if (!sync_2[i]) begin
					// Released, re-arm
					cnt[i]   <= '0;
					fired[i] <= 1'b0;
				end else if (!fired[i]) begin
					cnt[i] <= cnt[i] + 1'b1;
					if (cnt[i] == deb_cnt_t'(`MG_DEBOUNCE_CYCLES - 1)) begin
						fired[i]  <= 1'b1;
						strobe[i] <= 1'b1;
					end
				end
			end
		end
	end

	assign btn.start = strobe[0];
	assign btn.up    = strobe[1];
	assign btn.down  = strobe[2];
	assign btn.left  = strobe[3];
	assign btn.right = strobe[4];

endmodule

`default_nettype wire

//--- logic/player_ctrl.sv
//########################################
// Game state machine and player point
//########################################
`timescale 1ns/1ps
`default_nettype none
`include "matrix_game_config.svh"

module player_ctrl import matrix_game_pkg::*; (
	input logic clock_50,
	input logic arst_n,
	button_if.dst btn,
	output logic playing,
	output logic new_game,
	output row_array_t point_rows
);

	// Single lit pixel at the start position
	function automatic row_array_t init_point();
		row_array_t rows;
		rows = '0;
		rows[`MG_POINT_INIT_ROW][`MG_POINT_INIT_COL] = 1'b1;
		return rows;
	endfunction

	// Rotate one row toward the MSB
	function automatic row_t rot_msb(row_t r);
		return {r[6:0], r[7]};
	endfunction

	// Rotate one row toward the LSB
	function automatic row_t rot_lsb(row_t r);
		return {r[0], r[7:1]};
	endfunction

	localparam row_array_t POINT_INIT = init_point();

	game_state_t state;

	assign playing = (state == PLAY);

	//########################################
	// State and point registers
	//########################################
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state      <= IDLE;
			new_game   <= 1'b0;
			point_rows <= POINT_INIT;
		end else begin
			new_game <= 1'b0;
			case (state)
				IDLE: begin
					// Direction keys are ignored here
					if (btn.start) begin
						state      <= PLAY;
						new_game   <= 1'b1;
						point_rows <= POINT_INIT;
					end
				end
				PLAY: begin
					if (btn.start) begin
						// Pause, the point stays where it is
						state <= IDLE;
					end else if (btn.up) begin
						point_rows <= {point_rows[6:0], point_rows[7]};
					end else if (btn.down) begin
						point_rows <= {point_rows[0], point_rows[7:1]};
					end else if (btn.left) begin
						for (int r = 0; r < 8; r++) begin
							point_rows[r] <= rot_msb(point_rows[r]);
						end
					end else if (btn.right) begin
						for (int r = 0; r < 8; r++) begin
							point_rows[r] <= rot_lsb(point_rows[r]);
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/background_scroll.sv
//########################################
// Obstacle background
// Scrolls down one row per scroll period
//########################################
`timescale 1ns/1ps
`default_nettype none
`include "matrix_game_config.svh"

module background_scroll import matrix_game_pkg::*; (
	input logic clock_50,
	input logic arst_n,
	input logic playing,
	input logic new_game,
	output row_array_t backg_rows
);

	localparam row_array_t BACKG_INIT = {
		`MG_BACKG_INIT_7,
		`MG_BACKG_INIT_6,
		`MG_BACKG_INIT_5,
		`MG_BACKG_INIT_4,
		`MG_BACKG_INIT_3,
		`MG_BACKG_INIT_2,
		`MG_BACKG_INIT_1,
		`MG_BACKG_INIT_0
	};

	localparam scroll_cnt_t SCROLL_LAST = scroll_cnt_t'(`MG_SCROLL_TICKS - 1);

	scroll_cnt_t prescale;
	logic step;

	// End of one scroll period
	assign step = playing && (prescale == SCROLL_LAST);

	//########################################
	// Prescaler
	//########################################
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			prescale <= '0;
		end else if (new_game || step) begin
			prescale <= '0;
		end else if (playing) begin
			prescale <= prescale + 1'b1;
		end
	end

	//########################################
	// Background rows
	//########################################
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			backg_rows <= BACKG_INIT;
		end else if (new_game) begin
			backg_rows <= BACKG_INIT;
		end else if (step) begin
			// Row i takes row i+1, top row comes in empty
			backg_rows <= {row_t'(0), backg_rows[7:1]};
		end
	end

endmodule

`default_nettype wire

//--- logic/max7219_driver.sv
//########################################
// MAX7219 serial driver
// Set-up words once, then endless digit refresh
//########################################
`timescale 1ns/1ps
`default_nettype none
`include "matrix_game_config.svh"

module max7219_driver import matrix_game_pkg::*; (
	input logic clock_50,
	input logic arst_n,
	input row_array_t point_rows,
	input row_array_t backg_rows,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	localparam int DIV = `MG_SCLK_DIV;
	localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;
	// GAP plus the LOAD cycle make one half-period
	localparam int GAP_LAST = (DIV > 1) ? DIV - 2 : 0;

	// Steps 0..4 are set-up words, 5..12 are digits 1..8
	localparam logic [3:0] FIRST_DIGIT = 4'd5;
	localparam logic [3:0] LAST_STEP = 4'd12;

	drv_state_t state;
	logic [3:0] step;
	logic [DIV_W-1:0] div_cnt;
	logic [3:0] bit_cnt;
	frame_t shreg;
	frame_t next_frame;
	row_array_t overlay;
	row_t col_byte;
	idx_t col;
	logic half_tick;
	logic gap_tick;
	logic shift_en;

	//########################################
	// Frame content
	//########################################
	assign overlay = point_rows | backg_rows;

	// Digit d shows column 8 - d
	assign col = idx_t'(LAST_STEP - step);

	always_comb begin
		for (int r = 0; r < 8; r++) begin
			col_byte[7-r] = overlay[r][col];
		end
	end

	always_comb begin
		case (step)
			4'd0:    next_frame = {8'h09, 8'h00};
			4'd1:    next_frame = {8'h0A, 4'h0, `MG_INTENSITY};
			4'd2:    next_frame = {8'h0B, 8'h07};
			4'd3:    next_frame = {8'h0C, 8'h01};
			4'd4:    next_frame = {8'h0F, 8'h00};
			default: next_frame = {4'h0, step - 4'd4, col_byte};
		endcase
	end

	//########################################
	// Serial sequencer
	//########################################
	assign half_tick = (div_cnt == DIV_W'(DIV - 1));
	assign gap_tick  = (div_cnt == DIV_W'(GAP_LAST));

	// Next bit goes out on the falling clock edge
	assign shift_en = (state == SHIFT) && half_tick && max7219_clk && (bit_cnt != 4'd15);

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state       <= LOAD;
			step        <= '0;
			div_cnt     <= '0;
			bit_cnt     <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b1;
			max7219_din <= 1'b0;
		end else begin
			case (state)
				LOAD: begin
					max7219_ncs <= 1'b0;
					max7219_clk <= 1'b0;
					max7219_din <= next_frame[15];
					div_cnt     <= '0;
					bit_cnt     <= '0;
					step        <= (step == LAST_STEP) ? FIRST_DIGIT : step + 1'b1;
					state       <= SHIFT;
				end
				SHIFT: begin
					if (!half_tick) begin
						div_cnt <= div_cnt + 1'b1;
					end else begin
						div_cnt <= '0;
						if (!max7219_clk) begin
							max7219_clk <= 1'b1;
						end else if (bit_cnt == 4'd15) begin
							// Clock parks high, chip latches the word
							max7219_ncs <= 1'b1;
							state       <= GAP;
						end else begin
							max7219_clk <= 1'b0;
							max7219_din <= shreg[14];
							bit_cnt     <= bit_cnt + 1'b1;
						end
					end
				end
				GAP: begin
					if (gap_tick) begin
						div_cnt <= '0;
						state   <= LOAD;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: begin
					state <= LOAD;
				end
			endcase
		end
	end

	// Shift register, MSB first
	always_ff @(posedge clock_50) begin
		if (state == LOAD) begin
			shreg <= next_frame;
		end else if (shift_en) begin
			shreg <= {shreg[14:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

//--- logic/matrix_game_top.sv
//########################################
// LED matrix dodging game, top level
//########################################
`timescale 1ns/1ps
`default_nettype none

module matrix_game_top import matrix_game_pkg::*; (
	input logic clock_50,
	input logic arst_n,
	input logic start_button_n,
	input logic up_button_n,
	input logic down_button_n,
	input logic left_button_n,
	input logic right_button_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	logic playing;
	logic new_game;
	row_array_t point_rows;
	row_array_t backg_rows;

	button_if btn_bus ();

	button_debounce u_debounce (
		.clock_50       (clock_50),
		.arst_n         (arst_n),
		.start_button_n (start_button_n),
		.up_button_n    (up_button_n),
		.down_button_n  (down_button_n),
		.left_button_n  (left_button_n),
		.right_button_n (right_button_n),
		.btn            (btn_bus.src)
	);

	player_ctrl u_player (
		.clock_50   (clock_50),
		.arst_n     (arst_n),
		.btn        (btn_bus.dst),
		.playing    (playing),
		.new_game   (new_game),
		.point_rows (point_rows)
	);

	background_scroll u_backg (
		.clock_50   (clock_50),
		.arst_n     (arst_n),
		.playing    (playing),
		.new_game   (new_game),
		.backg_rows (backg_rows)
	);

	max7219_driver u_driver (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.point_rows  (point_rows),
		.backg_rows  (backg_rows),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

`default_nettype wire

//--- sim/max7219_monitor.sv
//########################################
// MAX7219 link monitor
// Decodes serial words and checks them
//########################################
`timescale 1ns/1ps
`default_nettype none

module max7219_monitor import matrix_game_pkg::*; (
	input logic arst_n,
	input logic max7219_din,
	input logic max7219_ncs,
	input logic max7219_clk,
	input logic check_en,
	input row_array_t exp_digits,
	output int error_count,
	output int frame_count,
	output int sweep_count
);

	frame_t rx_word;
	frame_t want;
	int clk_edges;
	logic in_frame;
	logic [7:0] next_addr;

	// Chip set-up sequence sent once after reset
	function automatic frame_t setup_word(input int idx);
		case (idx)
			0: return {8'h09, 8'h00};
			1: return {8'h0A, 8'h0A};
			2: return {8'h0B, 8'h07};
			3: return {8'h0C, 8'h01};
			default: return {8'h0F, 8'h00};
		endcase
	endfunction

	initial begin
		error_count = 0;
		frame_count = 0;
		sweep_count = 0;
		in_frame = 1'b0;
		next_addr = 8'd1;
	end

	always @(negedge arst_n) begin
		in_frame = 1'b0;
	end

	// Frame opens on the falling chip select
	always @(negedge max7219_ncs) begin
		if (arst_n === 1'b1) begin
			in_frame = 1'b1;
			clk_edges = 0;
			rx_word = '0;
		end
	end

	always @(posedge max7219_clk) begin
		if (in_frame && max7219_ncs === 1'b0) begin
			rx_word = {rx_word[14:0], max7219_din};
			clk_edges++;
		end
	end

	//########################################
	// Word check on the rising chip select
	//########################################
	always @(posedge max7219_ncs) begin
		if (in_frame) begin
			in_frame = 1'b0;
			if (clk_edges != 16) begin
				error_count++;
				$display("Frame %0d ended at time %0t after %0d clock edges instead of 16",
					frame_count, $time, clk_edges);
			end else if (frame_count < 5) begin
				want = setup_word(frame_count);
				if (rx_word !== want) begin
					error_count++;
					$display("Error at time %0t: set-up word %0d expected %04h, received %04h",
						$time, frame_count, want, rx_word);
				end
			end else begin
				if (rx_word[15:8] !== next_addr) begin
					error_count++;
					$display("Error at time %0t: address expected 8'h%02h, received 8'h%02h",
						$time, next_addr, rx_word[15:8]);
				end else if (check_en && rx_word[7:0] !== exp_digits[next_addr - 8'd1]) begin
					error_count++;
					$display("Error at time %0t: digit %0d expected 8'h%02h, received 8'h%02h",
						$time, next_addr, exp_digits[next_addr - 8'd1], rx_word[7:0]);
				end
				if (next_addr == 8'd8) begin
					sweep_count++;
					next_addr = 8'd1;
				end else begin
					next_addr = next_addr + 8'd1;
				end
			end
			frame_count++;
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_matrix_game.sv
//########################################
// Matrix game testbench
// Button stimulus, point model, final report
//########################################
`timescale 1ns/1ps
`default_nettype none
`include "matrix_game_config.svh"

module tb_matrix_game import matrix_game_pkg::*; ();

	localparam int unsigned SEED = 32'hf293;
	localparam int NUM_MOVES = 10;
	localparam int SETUP_TIMEOUT = 1000;
	localparam int SWEEP_TIMEOUT = 2000;
	localparam int SCROLL_WAIT = `MG_SCROLL_TICKS * 17 / 2;

	// Button codes
	localparam int BTN_START = 0;
	localparam int BTN_UP = 1;
	localparam int BTN_DOWN = 2;
	localparam int BTN_LEFT = 3;
	localparam int BTN_RIGHT = 4;

	logic clock_50;
	logic arst_n;
	logic start_button_n;
	logic up_button_n;
	logic down_button_n;
	logic left_button_n;
	logic right_button_n;
	wire max7219_din;
	wire max7219_ncs;
	wire max7219_clk;
	logic check_en;
	row_array_t exp_digits;
	int mon_errors;
	int mon_frames;
	int mon_sweeps;
	int timeout_count;
	int point_row;
	int point_col;
	int scroll_steps;
	logic game_on;
	int unsigned rnd;

	matrix_game_top uut (
		.clock_50       (clock_50),
		.arst_n         (arst_n),
		.start_button_n (start_button_n),
		.up_button_n    (up_button_n),
		.down_button_n  (down_button_n),
		.left_button_n  (left_button_n),
		.right_button_n (right_button_n),
		.max7219_din    (max7219_din),
		.max7219_ncs    (max7219_ncs),
		.max7219_clk    (max7219_clk)
	);

	max7219_monitor u_monitor (
		.arst_n      (arst_n),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk),
		.check_en    (check_en),
		.exp_digits  (exp_digits),
		.error_count (mon_errors),
		.frame_count (mon_frames),
		.sweep_count (mon_sweeps)
	);

	initial begin
		clock_50 = 1'b0;
		forever #4 clock_50 = ~clock_50;
	end

	//########################################
	// Reference model
	//########################################
	function automatic row_t start_backg_row(input int r);
		case (r)
			0: return `MG_BACKG_INIT_0;
			1: return `MG_BACKG_INIT_1;
			2: return `MG_BACKG_INIT_2;
			3: return `MG_BACKG_INIT_3;
			4: return `MG_BACKG_INIT_4;
			5: return `MG_BACKG_INIT_5;
			6: return `MG_BACKG_INIT_6;
			default: return `MG_BACKG_INIT_7;
		endcase
	endfunction

	// Digit d shows column 8 - d, row 0 in the MSB
	function automatic row_t expected_digit(input int prow, input int pcol,
		input int scroll, input int digit);
		row_t result;
		row_t src;
		int col;
		logic pix;
		col = 8 - digit;
		result = '0;
		for (int r = 0; r < 8; r++) begin
			pix = (r == prow) && (col == pcol);
			if (r + scroll < 8) begin
				src = start_backg_row(r + scroll);
				pix = pix | src[col];
			end
			result[7 - r] = pix;
		end
		return result;
	endfunction

	//########################################
	// Stimulus tasks
	//########################################
	task automatic press_button(input int which);
		@(posedge clock_50);
		case (which)
			BTN_START: start_button_n <= 1'b0;
			BTN_UP:    up_button_n <= 1'b0;
			BTN_DOWN:  down_button_n <= 1'b0;
			BTN_LEFT:  left_button_n <= 1'b0;
			default:   right_button_n <= 1'b0;
		endcase
		repeat (`MG_DEBOUNCE_CYCLES + 8) @(posedge clock_50);
		start_button_n <= 1'b1;
		up_button_n    <= 1'b1;
		down_button_n  <= 1'b1;
		left_button_n  <= 1'b1;
		right_button_n <= 1'b1;
		repeat (8) @(posedge clock_50);
	endtask

	// Point only moves while a game runs
	task automatic press_direction(input int dir);
		press_button(dir);
		if (game_on) begin
			case (dir)
				BTN_UP:   point_row = (point_row + 1) % 8;
				BTN_DOWN: point_row = (point_row + 7) % 8;
				BTN_LEFT: point_col = (point_col + 1) % 8;
				default:  point_col = (point_col + 7) % 8;
			endcase
		end
	endtask

	task automatic wait_setup();
		int cycles;
		cycles = 0;
		while (mon_frames < 5 && cycles < SETUP_TIMEOUT) begin
			@(posedge clock_50);
			cycles++;
		end
		if (mon_frames < 5) begin
			timeout_count++;
			$display("Timeout at time %0t: the five set-up frames never arrived", $time);
		end
	endtask

	task automatic wait_sweeps(input int n);
		int target;
		int cycles;
		target = mon_sweeps + n;
		cycles = 0;
		while (mon_sweeps < target && cycles < n * SWEEP_TIMEOUT) begin
			@(posedge clock_50);
			cycles++;
		end
		if (mon_sweeps < target) begin
			timeout_count++;
			$display("Timeout at time %0t: no complete digit sweep on the MAX7219 link", $time);
		end
	endtask

	// Two settling sweeps, then one checked sweep
	task automatic check_sweep();
		for (int d = 1; d <= 8; d++) begin
			exp_digits[d - 1] = expected_digit(point_row, point_col, scroll_steps, d);
		end
		wait_sweeps(2);
		check_en = 1'b1;
		wait_sweeps(1);
		check_en = 1'b0;
	endtask

	task automatic restart_model();
		game_on = 1'b1;
		point_row = `MG_POINT_INIT_ROW;
		point_col = `MG_POINT_INIT_COL;
		scroll_steps = 0;
	endtask

	//########################################
	// Test sequence
	//########################################
	initial begin
		rnd = $urandom(SEED);
		arst_n = 1'b0;
		start_button_n = 1'b1;
		up_button_n = 1'b1;
		down_button_n = 1'b1;
		left_button_n = 1'b1;
		right_button_n = 1'b1;
		check_en = 1'b0;
		exp_digits = '0;
		timeout_count = 0;
		restart_model();
		game_on = 1'b0;
		repeat (2) @(posedge clock_50);
		arst_n <= 1'b1;

		// Set-up words, then the idle image
		wait_setup();
		check_sweep();
		repeat (4) begin
			rnd = $urandom % 4;
			press_direction(int'(rnd) + 1);
		end
		check_sweep();

		// Game running, moves inside the first scroll period
		press_button(BTN_START);
		restart_model();
		check_sweep();
		for (int i = 0; i < NUM_MOVES; i++) begin
			rnd = $urandom % 4;
			press_direction(int'(rnd) + 1);
			check_sweep();
		end

		// Background gone after 8.5 periods
		repeat (SCROLL_WAIT) @(posedge clock_50);
		scroll_steps = 8;
		check_sweep();

		// Pause freezes the image
		press_button(BTN_START);
		game_on = 1'b0;
		check_sweep();
		rnd = $urandom % 4;
		press_direction(int'(rnd) + 1);
		check_sweep();

		// New game restores the start image
		press_button(BTN_START);
		restart_model();
		check_sweep();

		$display("Run complete: %0d errors, %0d timeouts", mon_errors, timeout_count);
		if (mon_errors == 0 && timeout_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- matrix_game_top.f
+incdir+logic
logic/matrix_game_pkg.sv
logic/button_if.sv
logic/button_debounce.sv
logic/player_ctrl.sv
logic/background_scroll.sv
logic/max7219_driver.sv
logic/matrix_game_top.sv
sim/max7219_monitor.sv
sim/tb_matrix_game.sv
